/* sources.f */
+incdir+tb
hw/eth_pkg.sv
hw/mii_rx_deframer.sv
hw/eth_addr_filter.sv
hw/eth_crc_check.sv
hw/rx_buffer_writer.sv
hw/eth_rx_top.sv
tb/tb_eth_rx.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the MII receive path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
   --top-module tb_eth_rx -f sources.f \
   && ./obj_dir/Vtb_eth_rx \
   && echo "simulation exited cleanly" \
   || { echo "simulation failed"; exit 1; }

/* tb/eth_frame_gen.svh */
`ifndef ETH_FRAME_GEN_SVH
`define ETH_FRAME_GEN_SVH

// IEEE 802.3 CRC-32 in reflected form, result is the FCS value
function automatic logic [31:0] ref_fcs(input byte_t data[$], input int n);
   logic [31:0] c;
   c = 32'hFFFF_FFFF;
   for (int i = 0; i < n; i++) begin
      c = c ^ {24'h00_0000, data[i]};
      for (int b = 0; b < 8; b++) begin
         c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
   end
   return ~c;
endfunction

// Receiver CRC register over the whole frame and its FCS, MSB-first bit order
function automatic crc_t crc_register_after(input byte_t data[$]);
   logic [31:0] c;
   crc_t        r;
   c = ~ref_fcs(data, data.size());
   for (int b = 0; b < 32; b++) begin
      r[b] = c[31-b];
   end
   return r;
endfunction

// Destination, source, random payload and FCS sent low byte first
task automatic build_frame(input logic [47:0] dest, input int payload_len,
                           input logic corrupt);
   logic [31:0] fcs;
   int          pos;
   frame_q.delete();
   for (int i = 5; i >= 0; i--) begin
      frame_q.push_back(dest[8*i +: 8]);
   end
   for (int i = 5; i >= 0; i--) begin
      frame_q.push_back(SRC_MAC[8*i +: 8]);
   end
   for (int i = 0; i < payload_len; i++) begin
      frame_q.push_back(byte_t'($urandom()));
   end
   fcs = ref_fcs(frame_q, frame_q.size());
   for (int i = 0; i < 4; i++) begin
      frame_q.push_back(fcs[8*i +: 8]);
   end
   // Damage after the FCS is fixed
   if (corrupt) begin
      pos          = 12 + int'($urandom() % 32'(payload_len));
      frame_q[pos] = frame_q[pos] ^ 8'h10;
   end
endtask

// Accepted when addressed to us or broadcast and the FCS matches
function automatic logic frame_accepted(input byte_t data[$]);
   int          n;
   logic [47:0] dest;
   logic [31:0] fcs;
   n = data.size();
   if (n < 10) begin
      return 1'b0;
   end
   dest = {data[0], data[1], data[2], data[3], data[4], data[5]};
   fcs  = {data[n-1], data[n-2], data[n-3], data[n-4]};
   return (dest == MAC || dest == 48'hFFFF_FFFF_FFFF) && fcs == ref_fcs(data, n - 4);
endfunction

task automatic send_nibble(input logic [3:0] nib);
   mrxdv = 1'b1;
   mrxd  = nib;
   tick();
endtask

// Seven preamble bytes and the SFD, each byte low nibble first
task automatic send_frame();
   byte_t b;
   for (int i = 0; i < 8 + frame_q.size(); i++) begin
      b = (i < 7) ? 8'h55 : (i == 7) ? 8'hD5 : frame_q[i - 8];
      send_nibble(b[3:0]);
      send_nibble(b[7:4]);
   end
   mrxdv = 1'b0;
   mrxd  = 4'h0;
endtask

`endif

/* tb/tb_eth_rx.sv */
module tb_eth_rx
   import eth_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [47:0] MAC        = 48'h02_0A_35_00_00_01;
   localparam logic [47:0] SRC_MAC    = 48'h02_00_00_AA_BB_CC;
   localparam int          BUF_BYTES  = 2048;
   localparam int          WA_W       = $clog2(BUF_BYTES / 4);
   // 8 frames of at most 200 bytes at 2 nibbles each, plus reads and gaps
   localparam int          MAX_CYCLES = 20000;
   localparam int          RCV_WINDOW = 20;

   logic            MRxClk;
   logic            ETH_PHY_RESETN;
   logic [3:0]      mrxd;
   logic            mrxdv;
   logic            rd_en;
   logic [WA_W-1:0] rd_addr;
   word_t           rd_data;
   logic            rcv_ack;
   logic            data_rcvd;
   rx_size_t        rx_size;
   crc_t            crc_value;
   logic            phy_dv_detected;

   // Last frame sent, and the frame the buffer should be holding
   byte_t frame_q[$];
   byte_t held_q[$];
   logic  held      = 1'b0;
   logic  ack_after = 1'b1;
   int    req_cnt   = 0;
   int    done_cnt  = 0;
   int    cycles    = 0;

   eth_rx_top #(
      .ETH_MAC_ADDR(MAC),
      .BUF_BYTES   (BUF_BYTES)
   ) i_eth_rx_top (
      .MRxClk           (MRxClk),
      .ETH_PHY_RESETN   (ETH_PHY_RESETN),
      .MRxD_i           (mrxd),
      .MRxDv_i          (mrxdv),
      .rd_en_i          (rd_en),
      .rd_addr_i        (rd_addr),
      .rd_data_o        (rd_data),
      .rcv_ack_i        (rcv_ack),
      .data_rcvd_o      (data_rcvd),
      .rx_size_o        (rx_size),
      .crc_value_o      (crc_value),
      .phy_dv_detected_o(phy_dv_detected)
   );

   always #10 MRxClk = ~MRxClk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   always @(posedge MRxClk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         fail_run($sformatf("Timeout, run still going after %0d cycles", cycles));
      end
   end

   // Inputs change and outputs are sampled 2 ns after the edge
   task automatic tick();
      @(posedge MRxClk);
      #2;
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_size(input string name, input rx_size_t got, input rx_size_t exp);
      if (got !== exp) begin
         fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_crc(input string name, input crc_t got, input crc_t exp);
      if (got !== exp) begin
         fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   `include "eth_frame_gen.svh"

   // Word reads, little-endian lanes within each word
   task automatic compare_buffer();
      word_t w;
      for (int i = 0; i < held_q.size(); i += 4) begin
         rd_en   = 1'b1;
         rd_addr = WA_W'(i / 4);
         tick();
         w = rd_data;
         for (int l = 0; l < 4 && i + l < held_q.size(); l++) begin
            check_byte($sformatf("rd_data_o byte %0d", i + l), w[8*l +: 8], held_q[i + l]);
         end
      end
      rd_en = 1'b0;
   endtask

   task automatic run_frame(input logic [47:0] dest, input int payload_len,
                            input logic corrupt, input logic ack);
      build_frame(dest, payload_len, corrupt);
      ack_after = ack;
      send_frame();
      req_cnt++;
      wait (done_cnt == req_cnt);
   endtask

   initial begin : compare_proc
      int   wait_cycles;
      logic fresh;
      rd_en   = 1'b0;
      rd_addr = '0;
      rcv_ack = 1'b0;
      forever begin
         wait (req_cnt != done_cnt);
         fresh = !held && frame_accepted(frame_q);
         if (fresh) begin
            held        = 1'b1;
            held_q      = frame_q;
            wait_cycles = 0;
            while (data_rcvd !== 1'b1) begin
               if (wait_cycles == RCV_WINDOW) begin
                  fail_run("data_rcvd_o did not rise within 20 cycles of DV dropping");
               end
               tick();
               wait_cycles++;
            end
         end else begin
            // Rejected or dropped frame leaves the level as it was
            repeat (RCV_WINDOW) begin
               tick();
               check_flag("data_rcvd_o", data_rcvd, held);
            end
         end
         // Every frame that reaches eof leaves its CRC register behind
         check_crc("crc_value_o", crc_value, crc_register_after(frame_q));
         if (held) begin
            check_size("rx_size_o", rx_size, rx_size_t'(held_q.size()));
            compare_buffer();
         end
         if (held && ack_after) begin
            rcv_ack = 1'b1;
            tick();
            rcv_ack = 1'b0;
            check_flag("data_rcvd_o", data_rcvd, 1'b0);
            held = 1'b0;
         end
         done_cnt++;
      end
   end

   initial begin : stimulus
      MRxClk         = 1'b0;
      ETH_PHY_RESETN = 1'b0;
      mrxd           = 4'h0;
      mrxdv          = 1'b0;
      void'($urandom(21));
      repeat (10) @(posedge MRxClk);
      #2;
      ETH_PHY_RESETN = 1'b1;
      check_flag("data_rcvd_o", data_rcvd, 1'b0);
      check_flag("phy_dv_detected_o", phy_dv_detected, 1'b0);
      check_size("rx_size_o", rx_size, '0);

      // Own address, then broadcast
      run_frame(MAC, 46, 1'b0, 1'b1);
      check_flag("phy_dv_detected_o", phy_dv_detected, 1'b1);
      run_frame(48'hFFFF_FFFF_FFFF, 60, 1'b0, 1'b1);
      // Foreign station followed by a good frame of odd length
      run_frame(48'h02_0A_35_00_00_02, 40, 1'b0, 1'b1);
      run_frame(MAC, 33, 1'b0, 1'b1);
      run_frame(MAC, 50, 1'b1, 1'b1);
      // Held frame, one dropped behind it, then release and receive again
      run_frame(MAC, 64, 1'b0, 1'b0);
      run_frame(MAC, 47, 1'b0, 1'b1);
      run_frame(MAC, 100, 1'b0, 1'b1);

      tick();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* hw/eth_rx_top.sv */
module eth_rx_top
   import eth_pkg::*;
#(
   parameter logic [47:0] ETH_MAC_ADDR = 48'h02_0A_35_00_00_01,
   parameter  int         BUF_BYTES    = 2048,
   localparam int         WA_W         = $clog2(BUF_BYTES / 4)
) (
   input  logic            MRxClk,
   input  logic            ETH_PHY_RESETN,
   input  logic [3:0]      MRxD_i,
   input  logic            MRxDv_i,
   input  logic            rd_en_i,
   input  logic [WA_W-1:0] rd_addr_i,
   output word_t           rd_data_o,
   input  logic            rcv_ack_i,
   output logic            data_rcvd_o,
   output rx_size_t        rx_size_o,
   output crc_t            crc_value_o,
   output logic            phy_dv_detected_o
);

   // Deframer to filter
   byte_t df_byte;
   logic  df_stb;
   logic  df_sof;
   logic  df_eof;

   // Filter to CRC
   byte_t af_byte;
   logic  af_stb;
   logic  af_sof;
   logic  af_eof;
   logic  af_addr_ok;

   // CRC to writer
   byte_t cc_byte;
   logic  cc_stb;
   logic  cc_eof;
   logic  cc_addr_ok;
   logic  cc_crc_ok;

   mii_rx_deframer u_deframer (
      .MRxClk           (MRxClk),
      .ETH_PHY_RESETN   (ETH_PHY_RESETN),
      .mrxd_i           (MRxD_i),
      .mrxdv_i          (MRxDv_i),
      .byte_o           (df_byte),
      .byte_stb_o       (df_stb),
      .sof_o            (df_sof),
      .eof_o            (df_eof),
      .phy_dv_detected_o(phy_dv_detected_o)
   );

   eth_addr_filter #(
      .ETH_MAC_ADDR(ETH_MAC_ADDR)
   ) u_addr_filter (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .byte_i        (df_byte),
      .byte_stb_i    (df_stb),
      .sof_i         (df_sof),
      .eof_i         (df_eof),
      .byte_o        (af_byte),
      .byte_stb_o    (af_stb),
      .sof_o         (af_sof),
      .eof_o         (af_eof),
      .addr_ok_o     (af_addr_ok)
   );

   eth_crc_check u_crc_check (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .byte_i        (af_byte),
      .byte_stb_i    (af_stb),
      .sof_i         (af_sof),
      .eof_i         (af_eof),
      .addr_ok_i     (af_addr_ok),
      .byte_o        (cc_byte),
      .byte_stb_o    (cc_stb),
      .eof_o         (cc_eof),
      .addr_ok_o     (cc_addr_ok),
      .crc_ok_o      (cc_crc_ok),
      .crc_value_o   (crc_value_o)
   );

   rx_buffer_writer #(
      .BUF_BYTES(BUF_BYTES)
   ) u_buffer_writer (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .byte_i        (cc_byte),
      .byte_stb_i    (cc_stb),
      .eof_i         (cc_eof),
      .addr_ok_i     (cc_addr_ok),
      .crc_ok_i      (cc_crc_ok),
      .rcv_ack_i     (rcv_ack_i),
      .rd_en_i       (rd_en_i),
      .rd_addr_i     (rd_addr_i),
      .rd_data_o     (rd_data_o),
      .data_rcvd_o   (data_rcvd_o),
      .rx_size_o     (rx_size_o)
   );

endmodule

/* hw/rx_buffer_writer.sv */
module rx_buffer_writer
   import eth_pkg::*;
#(
   parameter  int BUF_BYTES = 2048,
   localparam int WA_W      = $clog2(BUF_BYTES / 4)
) (
   input  logic            MRxClk,
   input  logic            ETH_PHY_RESETN,
   input  byte_t           byte_i,
   input  logic            byte_stb_i,
   input  logic            eof_i,
   input  logic            addr_ok_i,
   input  logic            crc_ok_i,
   input  logic            rcv_ack_i,
   input  logic            rd_en_i,
   input  logic [WA_W-1:0] rd_addr_i,
   output word_t           rd_data_o,
   output logic            data_rcvd_o,
   output rx_size_t        rx_size_o
);

   word_t     mem [BUF_BYTES/4];
   wr_state_e state_q;
   rx_size_t  wr_addr_q;
   logic      ovf_q;
   logic      wr_en;
   logic [3:0] wr_strb;
   word_t     wr_data;

   assign wr_en = byte_stb_i && !ovf_q && (state_q == WR_IDLE || state_q == WR_RECV);

   // Byte moved into its lane of the word
   assign wr_strb = 4'b0001 << wr_addr_q[1:0];
   assign wr_data = word_t'(byte_i) << (8 * wr_addr_q[1:0]);

   always_ff @(posedge MRxClk) begin
      if (wr_en) begin
         for (int l = 0; l < 4; l++) begin
            if (wr_strb[l]) begin
               mem[wr_addr_q[WA_W+1:2]][8*l +: 8] <= wr_data[8*l +: 8];
            end
         end
      end
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q     <= WR_IDLE;
         wr_addr_q   <= '0;
         ovf_q       <= 1'b0;
         data_rcvd_o <= 1'b0;
         rx_size_o   <= '0;
      end else begin
         if (wr_en) begin
            if (wr_addr_q == rx_size_t'(BUF_BYTES - 1)) begin
               ovf_q <= 1'b1;
            end else begin
               wr_addr_q <= wr_addr_q + 1'b1;
            end
         end
         if (rcv_ack_i) begin
            data_rcvd_o <= 1'b0;
         end
         case (state_q)
            WR_IDLE: begin
               if (byte_stb_i) begin
                  state_q <= WR_RECV;
               end
            end
            WR_RECV: begin
               if (eof_i) begin
                  wr_addr_q <= '0;
                  ovf_q     <= 1'b0;
                  if (addr_ok_i && crc_ok_i && !ovf_q) begin
                     rx_size_o   <= wr_addr_q;
                     data_rcvd_o <= 1'b1;
                     state_q     <= WR_HOLD;
                  end else begin
                     state_q <= WR_IDLE;
                  end
               end
            end
            WR_HOLD: begin
               if (rcv_ack_i) begin
                  state_q <= WR_IDLE;
               end else if (byte_stb_i) begin
                  state_q <= WR_DROP;
               end
            end
            default: begin
               // Frame started while held, discard it whole
               if (eof_i) begin
                  state_q <= (data_rcvd_o && !rcv_ack_i) ? WR_HOLD : WR_IDLE;
               end
            end
         endcase
      end
   end

   a_no_write_when_held : assert property (
      @(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      data_rcvd_o |-> !wr_en
   );

endmodule

/* hw/eth_crc_check.sv */
module eth_crc_check
   import eth_pkg::*;
(
   input  logic  MRxClk,
   input  logic  ETH_PHY_RESETN,
   input  byte_t byte_i,
   input  logic  byte_stb_i,
   input  logic  sof_i,
   input  logic  eof_i,
   input  logic  addr_ok_i,
   output byte_t byte_o,
   output logic  byte_stb_o,
   output logic  eof_o,
   output logic  addr_ok_o,
   output logic  crc_ok_o,
   output crc_t  crc_value_o
);

   crc_t crc_q;
   crc_t crc_seed;

   // One byte of CRC-32, data bits taken LSB first
   function automatic crc_t crc_byte(crc_t crc_in, byte_t data);
      crc_t r;
      logic fb;
      r = crc_in;
      for (int i = 0; i < 8; i++) begin
         fb = r[ETH_CRC_W-1] ^ data[i];
         r  = {r[ETH_CRC_W-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
      end
      return r;
   endfunction

   assign crc_seed = sof_i ? CRC_INIT : crc_q;

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q       <= CRC_INIT;
         crc_value_o <= '0;
         crc_ok_o    <= 1'b0;
         byte_stb_o  <= 1'b0;
         eof_o       <= 1'b0;
         addr_ok_o   <= 1'b0;
      end else begin
         byte_stb_o <= byte_stb_i;
         eof_o      <= eof_i;
         addr_ok_o  <= addr_ok_i;
         crc_ok_o   <= eof_i && (crc_q == CRC_RESIDUE);
         if (eof_i) begin
            crc_value_o <= crc_q;
            // Back to the seed so an empty frame cannot reuse a residue
            crc_q       <= CRC_INIT;
         end else if (byte_stb_i) begin
            crc_q <= crc_byte(crc_seed, byte_i);
         end
      end
   end

   always_ff @(posedge MRxClk) begin
      byte_o <= byte_i;
   end

   // A byte arriving together with eof would be missing from the residue
   a_no_byte_at_eof : assert property (
      @(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      eof_i |-> !byte_stb_i
   );

endmodule

/* hw/eth_addr_filter.sv */
module eth_addr_filter
   import eth_pkg::*;
#(
   parameter logic [47:0] ETH_MAC_ADDR = 48'h02_0A_35_00_00_01
) (
   input  logic  MRxClk,
   input  logic  ETH_PHY_RESETN,
   input  byte_t byte_i,
   input  logic  byte_stb_i,
   input  logic  sof_i,
   input  logic  eof_i,
   output byte_t byte_o,
   output logic  byte_stb_o,
   output logic  sof_o,
   output logic  eof_o,
   output logic  addr_ok_o
);

   logic [2:0] cnt_q;
   logic [2:0] idx;
   byte_t      mac_byte;
   logic       own_q;
   logic       bc_q;
   logic       own_hit;
   logic       bc_hit;

   // Byte position in the frame, sof always means position 0
   assign idx = sof_i ? 3'd0 : cnt_q;

   // Destination goes out most significant byte first
   always_comb begin
      case (idx)
         3'd0:    mac_byte = ETH_MAC_ADDR[47:40];
         3'd1:    mac_byte = ETH_MAC_ADDR[39:32];
         3'd2:    mac_byte = ETH_MAC_ADDR[31:24];
         3'd3:    mac_byte = ETH_MAC_ADDR[23:16];
         3'd4:    mac_byte = ETH_MAC_ADDR[15:8];
         default: mac_byte = ETH_MAC_ADDR[7:0];
      endcase
   end

   assign own_hit = (byte_i == mac_byte) && (sof_i || own_q);
   assign bc_hit  = (byte_i == 8'hFF) && (sof_i || bc_q);

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         cnt_q      <= '0;
         own_q      <= 1'b0;
         bc_q       <= 1'b0;
         addr_ok_o  <= 1'b0;
         byte_stb_o <= 1'b0;
         sof_o      <= 1'b0;
         eof_o      <= 1'b0;
      end else begin
         byte_stb_o <= byte_stb_i;
         sof_o      <= sof_i;
         eof_o      <= eof_i;
         if (eof_o) begin
            addr_ok_o <= 1'b0;
         end else if (byte_stb_i && idx < 3'd6) begin
            own_q     <= own_hit;
            bc_q      <= bc_hit;
            cnt_q     <= idx + 3'd1;
            // Decided on the sixth byte, held until eof
            addr_ok_o <= (idx == 3'd5) && (own_hit || bc_hit);
         end
      end
   end

   always_ff @(posedge MRxClk) begin
      byte_o <= byte_i;
   end

endmodule

/* hw/mii_rx_deframer.sv */
module mii_rx_deframer
   import eth_pkg::*;
(
   input  logic       MRxClk,
   input  logic       ETH_PHY_RESETN,
   input  logic [3:0] mrxd_i,
   input  logic       mrxdv_i,
   output byte_t      byte_o,
   output logic       byte_stb_o,
   output logic       sof_o,
   output logic       eof_o,
   output logic       phy_dv_detected_o
);

   rx_state_e  state_q;
   logic [3:0] low_nib_q;
   logic       first_q;

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q    <= RX_IDLE;
         byte_stb_o <= 1'b0;
         sof_o      <= 1'b0;
         eof_o      <= 1'b0;
         first_q    <= 1'b0;
      end else begin
         byte_stb_o <= 1'b0;
         sof_o      <= 1'b0;
         eof_o      <= 1'b0;
         case (state_q)
            RX_IDLE: begin
               if (mrxdv_i && mrxd_i == PRE_NIBBLE) begin
                  state_q <= RX_PREAMBLE;
               end
            end
            RX_PREAMBLE: begin
               // A drop before the SFD ends silently, no eof
               if (!mrxdv_i) begin
                  state_q <= RX_IDLE;
               end else if (mrxd_i == SFD_NIBBLE) begin
                  state_q <= RX_LOW_NIB;
                  first_q <= 1'b1;
               end else if (mrxd_i != PRE_NIBBLE) begin
                  state_q <= RX_IDLE;
               end
            end
            RX_LOW_NIB: begin
               if (!mrxdv_i) begin
                  state_q <= RX_IDLE;
                  eof_o   <= 1'b1;
               end else begin
                  state_q <= RX_HIGH_NIB;
               end
            end
            RX_HIGH_NIB: begin
               if (!mrxdv_i) begin
                  // Odd nibble count, the half byte is lost
                  state_q <= RX_IDLE;
                  eof_o   <= 1'b1;
               end else begin
                  state_q    <= RX_LOW_NIB;
                  byte_stb_o <= 1'b1;
                  sof_o      <= first_q;
                  first_q    <= 1'b0;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   // Nibble assembly, low nibble arrives first
   always_ff @(posedge MRxClk) begin
      if (state_q == RX_LOW_NIB) begin
         low_nib_q <= mrxd_i;
      end
      if (state_q == RX_HIGH_NIB) begin
         byte_o <= {mrxd_i, low_nib_q};
      end
   end

   // Sticky once the PHY has shown any activity
   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         phy_dv_detected_o <= 1'b0;
      end else if (mrxdv_i) begin
         phy_dv_detected_o <= 1'b1;
      end
   end

   // Each strobed byte is built from the two nibbles just before it
   a_no_stb_in_idle : assert property (
      @(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      byte_stb_o |-> $past(state_q) != RX_IDLE
                     && byte_o == {$past(mrxd_i), $past(mrxd_i, 2)}
   );

endmodule

/* hw/eth_pkg.sv */
package eth_pkg;

   // CRC-32 as used by the Ethernet FCS
   localparam int ETH_CRC_W = 32;
   localparam logic [ETH_CRC_W-1:0] CRC_POLY    = 32'h04C1_1DB7;
   localparam logic [ETH_CRC_W-1:0] CRC_INIT    = 32'hFFFF_FFFF;
   // Remainder left once the FCS itself has been run through the CRC
   localparam logic [ETH_CRC_W-1:0] CRC_RESIDUE = 32'hC704_DD7B;

   // MII nibbles of the preamble and the upper half of the SFD
   localparam logic [3:0] PRE_NIBBLE = 4'h5;
   localparam logic [3:0] SFD_NIBBLE = 4'hD;

   typedef logic [7:0]           byte_t;
   typedef logic [31:0]          word_t;
   typedef logic [10:0]          rx_size_t;
   typedef logic [ETH_CRC_W-1:0] crc_t;

   // Deframer states
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_LOW_NIB,
      RX_HIGH_NIB
   } rx_state_e;

   // Buffer writer states
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_RECV,
      WR_DROP,
      WR_HOLD
   } wr_state_e;

endpackage
